/* bench/io_device.sv */
`default_nettype none
`timescale 1ns/10ps

module io_device (
	input  wire                clk,
	input  wire                rst,
	input  wire                io_req,
	input  wire                io_write,
	input  mem_pkg::word_t     io_addr,
	input  mem_pkg::word_t     io_wdata,
	input  mem_pkg::byte_en_t  io_be,
	// latency of the next request, 0 means one cycle
	input  wire  [1:0]         ack_delay,
	output logic               io_ack,
	output mem_pkg::word_t     io_rdata
);

	mem_pkg::word_t regs [16];
	logic           pending;
	logic [2:0]     left;
	logic [2:0]     remain;
	logic [3:0]     idx;

	assign idx = io_addr[5:2];

	// every word gets its own value
	initial begin
		int i;
		for (i = 0; i < 16; i++) begin
			regs[i] = 32'h5a00_0000 ^ (i * 32'h0104_0a11);
		end
	end

	// ------------------------------------------------------------------
	// request, wait, single ack pulse
	// ------------------------------------------------------------------
	always @(posedge clk) begin
		if (rst) begin
			io_ack   <= 1'b0;
			io_rdata <= '0;
			pending  <= 1'b0;
			left     <= '0;
		end else begin
			io_ack <= 1'b0;
			// req is still high in the ack cycle, not a new access
			if (io_req && !io_ack) begin
				remain = pending ? left : {1'b0, ack_delay} + 3'd1;
				if (remain == 3'd1) begin
					io_ack   <= 1'b1;
					io_rdata <= regs[idx];
					pending  <= 1'b0;
					for (int b = 0; b < 4; b++) begin
						if (io_write && io_be[b]) begin
							regs[idx][8*b +: 8] <= io_wdata[8*b +: 8];
						end
					end
				end else begin
					pending <= 1'b1;
					left    <= remain - 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* bench/mem_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_tb;

	// eight fill stores and then random traffic
	localparam int N_INSTR     = 128;
	localparam int CYCLE_LIMIT = 6 * N_INSTR + 50;

	logic               clk = 1'b0;
	logic               rst;
	logic               in_val;
	logic               in_kill;
	logic               in_mem_req;
	logic               in_mem_write;
	mem_pkg::acc_size_t in_size;
	mem_pkg::ext_op_t   in_ext;
	logic               in_rf_we;
	mem_pkg::wb_sel_t   in_wb_sel;
	mem_pkg::word_t     in_alu_result;
	mem_pkg::word_t     in_store_data;
	mem_pkg::word_t     in_imm;
	mem_pkg::word_t     in_pc4;
	mem_pkg::reg_idx_t  in_rs2;
	mem_pkg::reg_idx_t  in_rd;
	mem_pkg::word_t     csr_nc_mask;
	mem_pkg::word_t     csr_nc_base;
	logic               stall;
	logic               rf_we;
	mem_pkg::reg_idx_t  rf_rd;
	mem_pkg::word_t     rf_data;
	logic               io_req;
	logic               io_write;
	mem_pkg::word_t     io_addr;
	mem_pkg::word_t     io_wdata;
	mem_pkg::byte_en_t  io_be;
	logic               io_ack;
	mem_pkg::word_t     io_rdata;
	logic [1:0]         ack_delay;

	// reference model state
	logic [31:0]        lfsr;
	mem_pkg::word_t     ram_pool [4];
	mem_pkg::word_t     io_pool [4];
	mem_pkg::word_t     ram_mirror [4];
	mem_pkg::word_t     io_mirror [4];
	logic               is_io;
	logic [1:0]         slot;
	logic               prev_we;
	mem_pkg::reg_idx_t  prev_rd;
	mem_pkg::word_t     prev_result;
	logic               exp_rf_we;
	mem_pkg::reg_idx_t  exp_rf_rd;
	mem_pkg::word_t     exp_rf_data;
	logic               cur_nc;
	mem_pkg::word_t     exp_io_addr;
	mem_pkg::byte_en_t  exp_io_be;
	logic               exp_io_write;
	mem_pkg::word_t     exp_io_wdata;
	mem_pkg::word_t     exp_io_wmask;
	int                 cycles = 0;

	mem_top mem_top_i (.*);

	io_device io_device_i (
		.clk(clk), .rst(rst), .io_req(io_req), .io_write(io_write),
		.io_addr(io_addr), .io_wdata(io_wdata), .io_be(io_be),
		.ack_delay(ack_delay), .io_ack(io_ack), .io_rdata(io_rdata)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------
	// failure reporting and run limit
	// ------------------------------------------------------------------
	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic value_mismatch(input string sig, input logic [31:0] got,
			input logic [31:0] want);
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, sig, got, want);
		abort_run();
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: instructions still pending after %0d cycles", cycles);
			abort_run();
		end
	end

	// ------------------------------------------------------------------
	// random source and reference rules
	// ------------------------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		// galois form of x^32 + x^22 + x^2 + x + 1
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic draw(input int nbits, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < nbits; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic mem_pkg::byte_en_t lane_mask(input mem_pkg::acc_size_t sz,
			input logic [1:0] off);
		mem_pkg::byte_en_t m;
		m = '0;
		case (sz)
			mem_pkg::SIZE_BYTE: m[off] = 1'b1;
			mem_pkg::SIZE_HALF: begin
				m[off]     = 1'b1;
				m[off + 1] = 1'b1;
			end
			default: m = 4'hf;
		endcase
		return m;
	endfunction

	// byte lanes widened to a bit mask
	function automatic mem_pkg::word_t lane_bits(input mem_pkg::byte_en_t lanes);
		mem_pkg::word_t m;
		m = '0;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b]) begin
				m[8*b +: 8] = 8'hff;
			end
		end
		return m;
	endfunction

	// store bytes placed in their lanes over a zero word
	function automatic mem_pkg::word_t place_lanes(input mem_pkg::word_t d,
			input logic [1:0] off, input mem_pkg::byte_en_t lanes);
		mem_pkg::word_t w;
		w = '0;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b]) begin
				w[8*b +: 8] = d[8*(b - off) +: 8];
			end
		end
		return w;
	endfunction

	function automatic mem_pkg::word_t load_value(input mem_pkg::word_t w,
			input logic [1:0] off, input mem_pkg::acc_size_t sz,
			input mem_pkg::ext_op_t ext);
		logic [7:0]  b;
		logic [15:0] h;
		logic        sgn;
		sgn = ext == mem_pkg::EXT_SIGNED;
		case (sz)
			mem_pkg::SIZE_BYTE: begin
				b = w[8*off +: 8];
				return {{24{sgn & b[7]}}, b};
			end
			mem_pkg::SIZE_HALF: begin
				h = w[8*off +: 16];
				return {{16{sgn & h[15]}}, h};
			end
			default: return w;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// instruction build and retire
	// ------------------------------------------------------------------
	// kind 0,1,7 load, 2,3 store, 4 alu, 5 killed store, 6 invalid store
	task automatic next_instr(input int n);
		logic [31:0]        r;
		logic [2:0]         kind;
		logic [1:0]         off;
		mem_pkg::acc_size_t sz;
		mem_pkg::word_t     addr;
		logic               wr;
		mem_pkg::reg_idx_t  rs2;
		mem_pkg::word_t     sdata;
		mem_pkg::byte_en_t  lanes;
		draw(3, r);
		kind = (n < 8) ? 3'd2 : r[2:0];
		draw(1, r);
		is_io = (n < 8) ? n[2] : r[0];
		draw(2, r);
		slot = (n < 8) ? n[1:0] : r[1:0];
		draw(2, r);
		case (r[1:0])
			2'd0:    sz = mem_pkg::SIZE_BYTE;
			2'd1:    sz = mem_pkg::SIZE_HALF;
			default: sz = mem_pkg::SIZE_WORD;
		endcase
		if (n < 8) begin
			sz = mem_pkg::SIZE_WORD;
		end
		draw(2, r);
		// natural alignment only
		off  = (sz == mem_pkg::SIZE_BYTE) ? r[1:0] :
			(sz == mem_pkg::SIZE_HALF) ? {r[0], 1'b0} : 2'b00;
		addr = (is_io ? io_pool[slot] : ram_pool[slot]) | off;
		wr   = kind == 3'd2 || kind == 3'd3 || kind == 3'd5 || kind == 3'd6;
		in_val       <= kind != 3'd6;
		in_kill      <= kind == 3'd5;
		in_mem_req   <= kind != 3'd4;
		in_mem_write <= wr;
		in_size      <= sz;
		in_rf_we     <= !(kind == 3'd2 || kind == 3'd3);
		draw(1, r);
		in_ext <= r[0] ? mem_pkg::EXT_UNSIGNED : mem_pkg::EXT_SIGNED;
		draw(2, r);
		if (kind == 3'd4) begin
			in_wb_sel <= (r[1:0] == 2'd2) ? mem_pkg::WB_PC4 :
				(r[1:0] == 2'd3) ? mem_pkg::WB_IMM : mem_pkg::WB_ALU;
		end else begin
			in_wb_sel <= wr ? mem_pkg::WB_ALU : mem_pkg::WB_MEM;
		end
		draw(32, r);
		in_alu_result <= (kind == 3'd4) ? r : addr;
		draw(32, r);
		in_store_data <= r;
		sdata = r;
		draw(32, r);
		in_imm <= r;
		draw(32, r);
		in_pc4 <= r;
		draw(3, r);
		in_rd <= 5'(r[2:0]);
		// half the time aim rs2 at the instruction in wb
		draw(4, r);
		rs2 = r[3] ? prev_rd : 5'(r[2:0]);
		in_rs2 <= rs2;
		draw(2, r);
		ack_delay <= r[1:0];
		// bus store data after the wb bypass
		if (wr && prev_we && prev_rd == rs2 && prev_rd != '0) begin
			sdata = prev_result;
		end
		lanes = lane_mask(sz, off);
		cur_nc       <= kind != 3'd4 && kind != 3'd5 && kind != 3'd6 && is_io;
		exp_io_addr  <= addr;
		exp_io_be    <= lanes;
		exp_io_write <= wr;
		exp_io_wdata <= place_lanes(sdata, off, lanes);
		exp_io_wmask <= lane_bits(lanes);
	endtask

	// called at the taking edge while inputs still hold the instruction
	task automatic take_effect();
		logic              live;
		logic              we;
		logic [1:0]        off;
		mem_pkg::byte_en_t lanes;
		mem_pkg::word_t    sdata;
		mem_pkg::word_t    word;
		mem_pkg::word_t    result;
		live  = in_val && !in_kill;
		off   = in_alu_result[1:0];
		lanes = lane_mask(in_size, off);
		sdata = (in_mem_write && prev_we && prev_rd == in_rs2 && prev_rd != '0) ?
			prev_result : in_store_data;
		word  = is_io ? io_mirror[slot] : ram_mirror[slot];
		case (in_wb_sel)
			mem_pkg::WB_PC4: result = in_pc4;
			mem_pkg::WB_IMM: result = in_imm;
			default:         result = in_alu_result;
		endcase
		if (live && in_mem_req && in_mem_write) begin
			for (int b = 0; b < 4; b++) begin
				if (lanes[b]) begin
					word[8*b +: 8] = sdata[8*(b - off) +: 8];
				end
			end
			if (is_io) begin
				io_mirror[slot] = word;
			end else begin
				ram_mirror[slot] = word;
			end
		end else if (live && in_mem_req) begin
			result = load_value(word, off, in_size, in_ext);
		end
		we = live && in_rf_we && in_rd != '0;
		exp_rf_we   <= we;
		exp_rf_rd   <= in_rd;
		exp_rf_data <= result;
		prev_we     = we;
		prev_rd     = in_rd;
		prev_result = result;
	endtask

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	a_reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> {rf_we, io_req, stall} == 3'b000)
		else value_mismatch("rf_we,io_req,stall", $sampled({rf_we, io_req, stall}), 0);
	a_rf_we: assert property (@(posedge clk) disable iff (rst) rf_we == exp_rf_we)
		else value_mismatch("rf_we", $sampled(rf_we), $sampled(exp_rf_we));
	a_rf_rd: assert property (@(posedge clk) disable iff (rst)
		exp_rf_we |-> rf_rd == exp_rf_rd)
		else value_mismatch("rf_rd", $sampled(rf_rd), $sampled(exp_rf_rd));
	a_rf_data: assert property (@(posedge clk) disable iff (rst)
		exp_rf_we |-> rf_data == exp_rf_data)
		else value_mismatch("rf_data", $sampled(rf_data), $sampled(exp_rf_data));
	// io access stalls until its ack cycle
	a_stall_io: assert property (@(posedge clk) disable iff (rst)
		cur_nc |-> stall == !io_ack)
		else value_mismatch("stall", $sampled(stall), !$sampled(io_ack));
	a_stall_none: assert property (@(posedge clk) disable iff (rst) !cur_nc |-> !stall)
		else value_mismatch("stall", $sampled(stall), 0);
	a_req_none: assert property (@(posedge clk) disable iff (rst) !cur_nc |-> !io_req)
		else value_mismatch("io_req", $sampled(io_req), 0);
	a_io_addr: assert property (@(posedge clk) disable iff (rst)
		io_req |-> io_addr == exp_io_addr)
		else value_mismatch("io_addr", $sampled(io_addr), $sampled(exp_io_addr));
	a_io_be: assert property (@(posedge clk) disable iff (rst) io_req |-> io_be == exp_io_be)
		else value_mismatch("io_be", $sampled(io_be), $sampled(exp_io_be));
	a_io_write: assert property (@(posedge clk) disable iff (rst)
		io_req |-> io_write == exp_io_write)
		else value_mismatch("io_write", $sampled(io_write), $sampled(exp_io_write));
	// only the enabled lanes carry store data
	a_io_wdata: assert property (@(posedge clk) disable iff (rst)
		io_req && io_write |-> (io_wdata & exp_io_wmask) == exp_io_wdata)
		else value_mismatch("io_wdata", $sampled(io_wdata & exp_io_wmask),
			$sampled(exp_io_wdata));

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin
		lfsr        = 32'hb61f;
		prev_we     = 1'b0;
		prev_rd     = '0;
		prev_result = '0;
		exp_rf_we   = 1'b0;
		exp_rf_rd   = '0;
		exp_rf_data = '0;
		cur_nc       = 1'b0;
		exp_io_addr  = '0;
		exp_io_be    = '0;
		exp_io_write = 1'b0;
		exp_io_wdata = '0;
		exp_io_wmask = '0;
		// ram words differ in bits 9:2 and io words sit in the window
		ram_pool = '{32'h0000_0010, 32'h0000_0014, 32'h0000_0200, 32'h0000_03fc};
		io_pool  = '{32'h1000_0000, 32'h1000_0004, 32'h1000_0020, 32'h1000_003c};
		rst           = 1'b1;
		in_val        = 1'b0;
		in_kill       = 1'b0;
		in_mem_req    = 1'b0;
		in_mem_write  = 1'b0;
		in_size       = mem_pkg::SIZE_WORD;
		in_ext        = mem_pkg::EXT_SIGNED;
		in_rf_we      = 1'b0;
		in_wb_sel     = mem_pkg::WB_ALU;
		in_alu_result = '0;
		in_store_data = '0;
		in_imm        = '0;
		in_pc4        = '0;
		in_rs2        = '0;
		in_rd         = '0;
		ack_delay     = 2'd0;
		csr_nc_mask   = mem_pkg::NC_MASK_RESET;
		csr_nc_base   = mem_pkg::NC_BASE_RESET;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// one idle cycle to see the reset state
		@(posedge clk);
		for (int n = 0; n < N_INSTR; n++) begin
			next_instr(n);
			// held while stalled
			do @(negedge clk); while (stall);
			@(posedge clk);
			take_effect();
		end
		in_val     <= 1'b0;
		in_mem_req <= 1'b0;
		cur_nc     <= 1'b0;
		repeat (3) @(posedge clk);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/data_ram.sv */
`default_nettype none
`timescale 1ns/10ps

module data_ram (
	input  wire                 clk,
	input  wire                 ram_en,
	input  wire                 ram_we,
	input  wire  [mem_pkg::RAM_AW-1:0] ram_addr,
	input  mem_pkg::word_t      ram_wdata,
	input  mem_pkg::byte_en_t   ram_be,
	output mem_pkg::word_t      ram_rdata
);

	// ------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------
	mem_pkg::word_t mem [mem_pkg::RAM_WORDS];

	// byte lane writes
	always_ff @(posedge clk) begin
		if (ram_en && ram_we) begin
			if (ram_be[0]) begin
				mem[ram_addr][7:0] <= ram_wdata[7:0];
			end
			if (ram_be[1]) begin
				mem[ram_addr][15:8] <= ram_wdata[15:8];
			end
			if (ram_be[2]) begin
				mem[ram_addr][23:16] <= ram_wdata[23:16];
			end
			if (ram_be[3]) begin
				mem[ram_addr][31:24] <= ram_wdata[31:24];
			end
		end
	end

	// ------------------------------------------------------------------
	// registered read
	// ------------------------------------------------------------------
	// old contents on a write cycle, wb only looks at it for loads
	always_ff @(posedge clk) begin
		if (ram_en) begin
			ram_rdata <= mem[ram_addr];
		end
	end

	// a write with no lanes would silently drop the store
	a_we_has_lanes: assert property (@(posedge clk)
		ram_en && ram_we |-> ram_be != '0);

endmodule

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// ------------------------------------------------------------------
	// basic widths
	// ------------------------------------------------------------------

	// data or address word
	typedef logic [31:0] word_t;

	// register file index
	typedef logic [4:0] reg_idx_t;

	// one enable per byte lane of a word
	typedef logic [3:0] byte_en_t;

	// ------------------------------------------------------------------
	// control encodings
	// ------------------------------------------------------------------

	// access width of a load or store
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} acc_size_t;

	// load extension, sign or zero
	typedef enum logic {
		EXT_SIGNED   = 1'b0,
		EXT_UNSIGNED = 1'b1
	} ext_op_t;

	// write-back result source
	typedef enum logic [1:0] {
		WB_ALU = 2'd0,
		WB_MEM = 2'd1,
		WB_PC4 = 2'd2,
		WB_IMM = 2'd3
	} wb_sel_t;

	// ------------------------------------------------------------------
	// data ram geometry and csr defaults
	// ------------------------------------------------------------------
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = 8;

	// non-cacheable window 0x1000_0000 .. 0x1fff_ffff
	localparam word_t NC_MASK_RESET = 32'h0fff_ffff;
	localparam word_t NC_BASE_RESET = 32'h1000_0000;

endpackage

`default_nettype wire

/* source/mem_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_stage (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 in_val,
	input  wire                 in_mem_req,
	input  wire                 in_mem_write,
	input  mem_pkg::acc_size_t  in_size,
	input  mem_pkg::ext_op_t    in_ext,
	input  wire                 in_rf_we,
	input  mem_pkg::wb_sel_t    in_wb_sel,
	input  mem_pkg::word_t      in_alu_result,
	input  mem_pkg::word_t      in_store_data,
	input  mem_pkg::word_t      in_imm,
	input  mem_pkg::word_t      in_pc4,
	input  mem_pkg::reg_idx_t   in_rd,
	input  mem_pkg::word_t      csr_nc_mask,
	input  mem_pkg::word_t      csr_nc_base,
	input  wire                 mem_enb,
	input  wire                 squash,
	input  wire                 bypass_sel,
	input  mem_pkg::word_t      wb_result,
	output logic                ram_en,
	output logic                ram_we,
	output logic [mem_pkg::RAM_AW-1:0] ram_addr,
	output mem_pkg::word_t      ram_wdata,
	output mem_pkg::byte_en_t   ram_be,
	output logic                io_write,
	output mem_pkg::word_t      io_addr,
	output mem_pkg::word_t      io_wdata,
	output mem_pkg::byte_en_t   io_be,
	output logic                nc_access,
	output logic                m_val,
	output logic                m_rf_we,
	output logic                m_mem_load,
	output mem_pkg::wb_sel_t    m_wb_sel,
	output mem_pkg::ext_op_t    m_ext,
	output mem_pkg::acc_size_t  m_size,
	output logic [1:0]          m_byte_off,
	output mem_pkg::reg_idx_t   m_rd,
	output mem_pkg::word_t      m_alu,
	output mem_pkg::word_t      m_imm,
	output mem_pkg::word_t      m_pc4
);

	logic              live;
	logic              req_fire;
	logic              nc_hit;
	logic [1:0]        byte_off;
	mem_pkg::byte_en_t be;
	mem_pkg::word_t    st_data;
	mem_pkg::word_t    st_lane;

	// ------------------------------------------------------------------
	// address classification
	// ------------------------------------------------------------------
	assign live      = in_val & ~squash;
	assign req_fire  = live & in_mem_req;
	// address bits outside the mask must match the base
	assign nc_hit    = (in_alu_result & ~csr_nc_mask) == csr_nc_base;
	assign nc_access = req_fire & nc_hit;
	assign byte_off  = in_alu_result[1:0];

	// lane enables from size and offset
	always_comb begin
		case (in_size)
			mem_pkg::SIZE_BYTE: be = 4'b0001 << byte_off;
			mem_pkg::SIZE_HALF: be = 4'b0011 << byte_off;
			default:            be = 4'b1111;
		endcase
	end

	// store data, bypassed from wb when rs2 hits its rd
	assign st_data = bypass_sel ? wb_result : in_store_data;
	assign st_lane = st_data << {byte_off, 3'b000};

	// ------------------------------------------------------------------
	// ram and io requests
	// ------------------------------------------------------------------
	// ram only on the taking edge of a cacheable request
	assign ram_en    = req_fire & ~nc_hit & mem_enb;
	assign ram_we    = ram_en & in_mem_write;
	assign ram_addr  = in_alu_result[mem_pkg::RAM_AW+1:2];
	assign ram_wdata = st_lane;
	assign ram_be    = be;

	// io fields quiet unless the access is non-cacheable
	assign io_write = nc_access & in_mem_write;
	assign io_addr  = nc_access ? in_alu_result : '0;
	assign io_wdata = io_write ? st_lane : '0;
	assign io_be    = nc_access ? be : '0;

	// ------------------------------------------------------------------
	// mem to wb register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			m_val      <= 1'b0;
			m_rf_we    <= 1'b0;
			m_mem_load <= 1'b0;
		end else if (mem_enb) begin
			// killed or empty slot becomes a bubble
			m_val      <= live;
			m_rf_we    <= live & in_rf_we;
			m_mem_load <= req_fire & ~in_mem_write;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (mem_enb) begin
			m_wb_sel   <= in_wb_sel;
			m_ext      <= in_ext;
			m_size     <= in_size;
			m_byte_off <= byte_off;
			m_rd       <= in_rd;
			m_alu      <= in_alu_result;
			m_imm      <= in_imm;
			m_pc4      <= in_pc4;
		end
	end

	// natural alignment of every access that goes out
	a_align_word: assert property (@(posedge clk) disable iff (rst)
		req_fire && in_size == mem_pkg::SIZE_WORD |-> byte_off == 2'b00);
	a_align_half: assert property (@(posedge clk) disable iff (rst)
		req_fire && in_size == mem_pkg::SIZE_HALF |-> byte_off[0] == 1'b0);

endmodule

`default_nettype wire

/* source/mem_top.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_top (
	input  wire                 clk,
	input  wire                 rst,
	// instruction from execute
	input  wire                 in_val,
	input  wire                 in_kill,
	input  wire                 in_mem_req,
	input  wire                 in_mem_write,
	input  mem_pkg::acc_size_t  in_size,
	input  mem_pkg::ext_op_t    in_ext,
	input  wire                 in_rf_we,
	input  mem_pkg::wb_sel_t    in_wb_sel,
	input  mem_pkg::word_t      in_alu_result,
	input  mem_pkg::word_t      in_store_data,
	input  mem_pkg::word_t      in_imm,
	input  mem_pkg::word_t      in_pc4,
	input  mem_pkg::reg_idx_t   in_rs2,
	input  mem_pkg::reg_idx_t   in_rd,
	// non-cacheable window csr
	input  mem_pkg::word_t      csr_nc_mask,
	input  mem_pkg::word_t      csr_nc_base,
	// back pressure and register file port
	output logic                stall,
	output logic                rf_we,
	output mem_pkg::reg_idx_t   rf_rd,
	output mem_pkg::word_t      rf_data,
	// io bus
	output logic                io_req,
	output logic                io_write,
	output mem_pkg::word_t      io_addr,
	output mem_pkg::word_t      io_wdata,
	output mem_pkg::byte_en_t   io_be,
	input  wire                 io_ack,
	input  mem_pkg::word_t      io_rdata
);

	// ------------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------------
	logic                        ram_en;
	logic                        ram_we;
	logic [mem_pkg::RAM_AW-1:0]  ram_addr;
	mem_pkg::word_t              ram_wdata;
	mem_pkg::byte_en_t           ram_be;
	mem_pkg::word_t              ram_rdata;
	logic                        nc_access;
	logic                        mem_enb;
	logic                        squash;
	logic                        bypass_sel;
	logic                        wb_we;
	mem_pkg::reg_idx_t           wb_rd;
	mem_pkg::word_t              wb_result;

	// mem to wb register
	logic                        m_val;
	logic                        m_rf_we;
	logic                        m_mem_load;
	mem_pkg::wb_sel_t            m_wb_sel;
	mem_pkg::ext_op_t            m_ext;
	mem_pkg::acc_size_t          m_size;
	logic [1:0]                  m_byte_off;
	mem_pkg::reg_idx_t           m_rd;
	mem_pkg::word_t              m_alu;
	mem_pkg::word_t              m_imm;
	mem_pkg::word_t              m_pc4;

	// ------------------------------------------------------------------
	// blocks
	// ------------------------------------------------------------------
	mem_stage mem_stage_i (
		.clk(clk), .rst(rst), .in_val(in_val), .in_mem_req(in_mem_req),
		.in_mem_write(in_mem_write), .in_size(in_size), .in_ext(in_ext),
		.in_rf_we(in_rf_we), .in_wb_sel(in_wb_sel), .in_alu_result(in_alu_result),
		.in_store_data(in_store_data), .in_imm(in_imm), .in_pc4(in_pc4),
		.in_rd(in_rd), .csr_nc_mask(csr_nc_mask), .csr_nc_base(csr_nc_base),
		.mem_enb(mem_enb), .squash(squash), .bypass_sel(bypass_sel),
		.wb_result(wb_result), .ram_en(ram_en), .ram_we(ram_we),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_be(ram_be),
		.io_write(io_write), .io_addr(io_addr), .io_wdata(io_wdata),
		.io_be(io_be), .nc_access(nc_access), .m_val(m_val), .m_rf_we(m_rf_we),
		.m_mem_load(m_mem_load), .m_wb_sel(m_wb_sel), .m_ext(m_ext),
		.m_size(m_size), .m_byte_off(m_byte_off), .m_rd(m_rd), .m_alu(m_alu),
		.m_imm(m_imm), .m_pc4(m_pc4)
	);

	// cacheable store, stands in for l1d
	data_ram data_ram_i (
		.clk(clk), .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_be(ram_be), .ram_rdata(ram_rdata)
	);

	pipeline_ctrl pipeline_ctrl_i (
		.clk(clk), .rst(rst), .in_val(in_val), .in_kill(in_kill),
		.in_mem_write(in_mem_write), .in_rs2(in_rs2), .nc_access(nc_access),
		.io_ack(io_ack), .wb_rd(wb_rd), .wb_we(wb_we), .stall(stall),
		.mem_enb(mem_enb), .squash(squash), .bypass_sel(bypass_sel),
		.io_req(io_req)
	);

	wb_stage wb_stage_i (
		.clk(clk), .rst(rst), .m_val(m_val), .m_rf_we(m_rf_we),
		.m_mem_load(m_mem_load), .m_wb_sel(m_wb_sel), .m_ext(m_ext),
		.m_size(m_size), .m_byte_off(m_byte_off), .m_rd(m_rd), .m_alu(m_alu),
		.m_imm(m_imm), .m_pc4(m_pc4), .ram_rdata(ram_rdata),
		.io_rdata(io_rdata), .io_ack(io_ack), .mem_enb(mem_enb),
		.rf_we(rf_we), .rf_rd(rf_rd), .rf_data(rf_data), .wb_we(wb_we),
		.wb_rd(wb_rd), .wb_result(wb_result)
	);

endmodule

`default_nettype wire

/* source/pipeline_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module pipeline_ctrl (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 in_val,
	input  wire                 in_kill,
	input  wire                 in_mem_write,
	input  mem_pkg::reg_idx_t   in_rs2,
	input  wire                 nc_access,
	input  wire                 io_ack,
	input  mem_pkg::reg_idx_t   wb_rd,
	input  wire                 wb_we,
	output logic                stall,
	output logic                mem_enb,
	output logic                squash,
	output logic                bypass_sel,
	output logic                io_req
);

	// io handshake tracking
	typedef enum logic [1:0] {
		IO_IDLE = 2'd0,
		IO_WAIT = 2'd1,
		IO_DONE = 2'd2
	} io_wait_state_t;

	io_wait_state_t state_q;
	io_wait_state_t state_d;

	// ------------------------------------------------------------------
	// io wait fsm
	// ------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			IO_IDLE: begin
				if (io_req && io_ack) begin
					state_d = IO_DONE;
				end else if (io_req) begin
					state_d = IO_WAIT;
				end
			end
			IO_WAIT: begin
				if (io_ack) begin
					state_d = IO_DONE;
				end
			end
			// one quiet cycle for io_req
			default: state_d = IO_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IO_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// held through wait even if the request goes away
	assign io_req = (state_q == IO_WAIT) | ((state_q == IO_IDLE) & nc_access);

	// ------------------------------------------------------------------
	// stall, kill, bypass
	// ------------------------------------------------------------------
	// a new io access right after ack still has to wait
	assign stall   = (io_req & ~io_ack) | ((state_q == IO_DONE) & nc_access);
	assign mem_enb = ~stall;
	assign squash  = in_kill;

	// store picks up the value being written back this cycle
	assign bypass_sel = in_val & in_mem_write & wb_we & (wb_rd == in_rs2) & (wb_rd != '0);

	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		io_ack |-> io_req);
	a_stall_bounded: assert property (@(posedge clk) disable iff (rst)
		$rose(stall) |-> ##[1:64] !stall);

endmodule

`default_nettype wire

/* source/wb_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module wb_stage (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 m_val,
	input  wire                 m_rf_we,
	input  wire                 m_mem_load,
	input  mem_pkg::wb_sel_t    m_wb_sel,
	input  mem_pkg::ext_op_t    m_ext,
	input  mem_pkg::acc_size_t  m_size,
	input  wire  [1:0]          m_byte_off,
	input  mem_pkg::reg_idx_t   m_rd,
	input  mem_pkg::word_t      m_alu,
	input  mem_pkg::word_t      m_imm,
	input  mem_pkg::word_t      m_pc4,
	input  mem_pkg::word_t      ram_rdata,
	input  mem_pkg::word_t      io_rdata,
	input  wire                 io_ack,
	input  wire                 mem_enb,
	output logic                rf_we,
	output mem_pkg::reg_idx_t   rf_rd,
	output mem_pkg::word_t      rf_data,
	output logic                wb_we,
	output mem_pkg::reg_idx_t   wb_rd,
	output mem_pkg::word_t      wb_result
);

	logic           io_sel;
	mem_pkg::word_t io_data_q;
	mem_pkg::word_t load_word;
	mem_pkg::word_t load_sh;
	mem_pkg::word_t load_ext;
	logic           sx;

	// ------------------------------------------------------------------
	// io read capture
	// ------------------------------------------------------------------
	// data is only valid during the ack pulse
	always_ff @(posedge clk) begin
		if (io_ack) begin
			io_data_q <= io_rdata;
		end
	end

	// an instruction taken in an ack cycle got its data from io
	always_ff @(posedge clk) begin
		if (rst) begin
			io_sel <= 1'b0;
		end else if (mem_enb) begin
			io_sel <= io_ack;
		end
	end

	// ------------------------------------------------------------------
	// load align and extend
	// ------------------------------------------------------------------
	assign load_word = io_sel ? io_data_q : ram_rdata;
	assign load_sh   = load_word >> {m_byte_off, 3'b000};
	assign sx        = m_ext == mem_pkg::EXT_SIGNED;

	always_comb begin
		case (m_size)
			mem_pkg::SIZE_BYTE: load_ext = {{24{sx & load_sh[7]}}, load_sh[7:0]};
			mem_pkg::SIZE_HALF: load_ext = {{16{sx & load_sh[15]}}, load_sh[15:0]};
			default:            load_ext = load_sh;
		endcase
	end

	// result select, non-load falls back to the alu value
	always_comb begin
		case (m_wb_sel)
			mem_pkg::WB_MEM: wb_result = m_mem_load ? load_ext : m_alu;
			mem_pkg::WB_PC4: wb_result = m_pc4;
			mem_pkg::WB_IMM: wb_result = m_imm;
			default:         wb_result = m_alu;
		endcase
	end

	// ------------------------------------------------------------------
	// register file port
	// ------------------------------------------------------------------
	// x0 is never written
	assign rf_we   = m_val & m_rf_we & (m_rd != '0);
	assign rf_rd   = m_rd;
	assign rf_data = wb_result;
	assign wb_we   = rf_we;
	assign wb_rd   = m_rd;

endmodule

`default_nettype wire

/* sources.f */
source/mem_pkg.sv
source/mem_stage.sv
source/data_ram.sv
source/pipeline_ctrl.sv
source/wb_stage.sv
source/mem_top.sv
bench/io_device.sv
bench/mem_tb.sv
